// ==== leaf_pkg.sv ====
package leaf_pkg;

    // Field widths of a network packet.
    localparam int LEAF_W = 5;
    localparam int PORT_W = 4;
    localparam int ADDR_W = 7;
    localparam int WORD_W = 32;

    // Kernel port counts.
    localparam int NUM_IN_PORTS  = 2;
    localparam int NUM_OUT_PORTS = 5;

    typedef logic [LEAF_W-1:0] leaf_id_t;
    typedef logic [PORT_W-1:0] port_id_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [WORD_W-1:0] word_t;

    // Packet layout, top bit first.
    typedef struct packed {
        logic     valid;
        leaf_id_t leaf;
        port_id_t port;
        addr_t    addr;
        word_t    payload;
    } packet_t;

    // Destination of one output port, sits in payload bits [8:0] of a route write.
    typedef struct packed {
        leaf_id_t leaf;
        port_id_t port;
    } route_t;

endpackage

// ==== leaf_packet_rx.sv ====
module leaf_packet_rx #(
    parameter leaf_pkg::leaf_id_t LEAF_ID = 5'd3
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  leaf_pkg::packet_t                   din,
    output logic                                route_we,
    output leaf_pkg::addr_t                     route_idx,
    output leaf_pkg::route_t                    route_data,
    output logic [leaf_pkg::NUM_IN_PORTS-1:0]   wr_en,
    output leaf_pkg::word_t                     wr_data
);

    leaf_pkg::packet_t pkt_q;
    logic              hit;

    // Input register.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pkt_q <= '0;
        end else begin
            pkt_q <= din;
        end
    end

    assign hit = pkt_q.valid && (pkt_q.leaf == LEAF_ID);

    // Port 0 is a route write, ports 1 and 2 feed the input FIFOs.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            route_we <= 1'b0;
            wr_en    <= '0;
        end else begin
            route_we <= hit && (pkt_q.port == leaf_pkg::port_id_t'(0));
            for (int i = 0; i < leaf_pkg::NUM_IN_PORTS; i++) begin
                wr_en[i] <= hit && (pkt_q.port == leaf_pkg::port_id_t'(i + 1));
            end
        end
    end

    always_ff @(posedge clk) begin
        route_idx  <= pkt_q.addr;
        route_data <= leaf_pkg::route_t'(pkt_q.payload[8:0]);
        wr_data    <= pkt_q.payload;
    end

endmodule

// ==== leaf_port_fifo.sv ====
module leaf_port_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            wr_en,
    input  leaf_pkg::word_t wr_data,
    output logic            vld,
    output leaf_pkg::word_t data,
    input  logic            ack
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] cnt_t;

    leaf_pkg::word_t mem [FIFO_DEPTH];
    ptr_t            rd_ptr;
    ptr_t            wr_ptr;
    cnt_t            count;
    logic            push;
    logic            pop;

    // A write into a full FIFO is lost.
    assign push = wr_en && (count != cnt_t'(FIFO_DEPTH));
    assign pop  = vld && ack;
    assign vld  = (count != '0);
    assign data = mem[rd_ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_t'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_t'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

endmodule

// ==== leaf_user_kernel.sv ====
module leaf_user_kernel (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic                                          ap_start,
    input  logic [leaf_pkg::NUM_IN_PORTS-1:0]             in_vld,
    output logic [leaf_pkg::NUM_IN_PORTS-1:0]             in_ack,
    input  leaf_pkg::word_t [leaf_pkg::NUM_IN_PORTS-1:0]  in_data,
    output logic [leaf_pkg::NUM_OUT_PORTS-1:0]            res_vld,
    input  logic [leaf_pkg::NUM_OUT_PORTS-1:0]            res_ack,
    output leaf_pkg::word_t [leaf_pkg::NUM_OUT_PORTS-1:0] res_data
);

    logic started;
    logic take;

    // Operands are taken as a pair, only once every result port is free.
    assign take   = started && (&in_vld) && !(|res_vld);
    assign in_ack = {leaf_pkg::NUM_IN_PORTS{take}};

    // Start flag stays set until reset.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            started <= 1'b0;
        end else if (ap_start) begin
            started <= 1'b1;
        end
    end

    // Each result stays valid until the transmit stage takes it.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_vld <= '0;
        end else begin
            for (int j = 0; j < leaf_pkg::NUM_OUT_PORTS; j++) begin
                if (take) begin
                    res_vld[j] <= 1'b1;
                end else if (res_vld[j] && res_ack[j]) begin
                    res_vld[j] <= 1'b0;
                end
            end
        end
    end

    // Result j+1 is a + (j+1)*b, wrapping at 32 bits.
    always_ff @(posedge clk) begin
        if (take) begin
            for (int j = 0; j < leaf_pkg::NUM_OUT_PORTS; j++) begin
                res_data[j] <= in_data[0] + in_data[1] * leaf_pkg::word_t'(j + 1);
            end
        end
    end

endmodule

// ==== leaf_packet_tx.sv ====
module leaf_packet_tx (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic                                          resend,
    input  logic                                          route_we,
    input  leaf_pkg::addr_t                               route_idx,
    input  leaf_pkg::route_t                              route_data,
    input  logic [leaf_pkg::NUM_OUT_PORTS-1:0]            res_vld,
    input  leaf_pkg::word_t [leaf_pkg::NUM_OUT_PORTS-1:0] res_data,
    output logic [leaf_pkg::NUM_OUT_PORTS-1:0]            res_ack,
    output leaf_pkg::packet_t                             dout
);

    typedef logic [$clog2(leaf_pkg::NUM_OUT_PORTS)-1:0] out_idx_t;

    leaf_pkg::route_t  routes [leaf_pkg::NUM_OUT_PORTS];
    out_idx_t          rr_ptr;
    out_idx_t          grant_idx;
    logic              grant_vld;
    leaf_pkg::packet_t pkt;
    leaf_pkg::packet_t dout_q;

    // Route table, one destination per output port.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < leaf_pkg::NUM_OUT_PORTS; i++) begin
                routes[i] <= '0;
            end
        end else if (route_we &&
                     (route_idx < leaf_pkg::addr_t'(leaf_pkg::NUM_OUT_PORTS))) begin
            routes[out_idx_t'(route_idx)] <= route_data;
        end
    end

    // Round-robin search starting at rr_ptr.
    always_comb begin
        int cand;
        cand      = 0;
        grant_vld = 1'b0;
        grant_idx = '0;
        for (int i = 0; i < leaf_pkg::NUM_OUT_PORTS; i++) begin
            cand = (int'(rr_ptr) + i) % leaf_pkg::NUM_OUT_PORTS;
            if (!grant_vld && res_vld[cand]) begin
                grant_vld = 1'b1;
                grant_idx = out_idx_t'(cand);
            end
        end
        // Nothing leaves while the tree asks for a resend.
        if (resend) begin
            grant_vld = 1'b0;
        end
    end

    always_comb begin
        res_ack = '0;
        if (grant_vld) begin
            res_ack[grant_idx] = 1'b1;
        end
    end

    always_comb begin
        pkt.valid   = 1'b1;
        pkt.leaf    = routes[grant_idx].leaf;
        pkt.port    = routes[grant_idx].port;
        pkt.addr    = leaf_pkg::addr_t'(grant_idx);
        pkt.payload = res_data[grant_idx];
    end

    // Output register holds its packet until a cycle with resend low has shown it.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dout_q <= '0;
            rr_ptr <= '0;
        end else if (!resend) begin
            dout_q <= grant_vld ? pkt : '0;
            if (grant_vld) begin
                rr_ptr <= (grant_idx == out_idx_t'(leaf_pkg::NUM_OUT_PORTS - 1)) ?
                          '0 : grant_idx + 1'b1;
            end
        end
    end

    assign dout = resend ? '0 : dout_q;

endmodule

// ==== leaf_top.sv ====
module leaf_top #(
    parameter leaf_pkg::leaf_id_t LEAF_ID    = 5'd3,
    parameter int                 FIFO_DEPTH = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    input  leaf_pkg::packet_t din,
    output leaf_pkg::packet_t dout,
    input  logic              resend,
    input  logic              ap_start
);

    logic                                          route_we;
    leaf_pkg::addr_t                               route_idx;
    leaf_pkg::route_t                              route_data;
    logic [leaf_pkg::NUM_IN_PORTS-1:0]             wr_en;
    leaf_pkg::word_t                               wr_data;
    logic [leaf_pkg::NUM_IN_PORTS-1:0]             fifo_vld;
    logic [leaf_pkg::NUM_IN_PORTS-1:0]             fifo_ack;
    leaf_pkg::word_t [leaf_pkg::NUM_IN_PORTS-1:0]  fifo_data;
    logic [leaf_pkg::NUM_OUT_PORTS-1:0]            res_vld;
    logic [leaf_pkg::NUM_OUT_PORTS-1:0]            res_ack;
    leaf_pkg::word_t [leaf_pkg::NUM_OUT_PORTS-1:0] res_data;

    leaf_packet_rx #(
        .LEAF_ID (LEAF_ID)
    ) i_packet_rx (
        .clk        (clk),
        .rst_n      (rst_n),
        .din        (din),
        .route_we   (route_we),
        .route_idx  (route_idx),
        .route_data (route_data),
        .wr_en      (wr_en),
        .wr_data    (wr_data)
    );

    // One input FIFO per kernel operand port.
    for (genvar i = 0; i < leaf_pkg::NUM_IN_PORTS; i++) begin : g_in_fifo
        leaf_port_fifo #(
            .FIFO_DEPTH (FIFO_DEPTH)
        ) i_port_fifo (
            .clk     (clk),
            .rst_n   (rst_n),
            .wr_en   (wr_en[i]),
            .wr_data (wr_data),
            .vld     (fifo_vld[i]),
            .data    (fifo_data[i]),
            .ack     (fifo_ack[i])
        );
    end

    leaf_user_kernel i_user_kernel (
        .clk      (clk),
        .rst_n    (rst_n),
        .ap_start (ap_start),
        .in_vld   (fifo_vld),
        .in_ack   (fifo_ack),
        .in_data  (fifo_data),
        .res_vld  (res_vld),
        .res_ack  (res_ack),
        .res_data (res_data)
    );

    leaf_packet_tx i_packet_tx (
        .clk        (clk),
        .rst_n      (rst_n),
        .resend     (resend),
        .route_we   (route_we),
        .route_idx  (route_idx),
        .route_data (route_data),
        .res_vld    (res_vld),
        .res_data   (res_data),
        .res_ack    (res_ack),
        .dout       (dout)
    );

endmodule

// ==== tb_clock_gen.sv ====
module tb_clock_gen (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD  = 10;
    localparam int RESET_CYCLES = 5;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // Reset is released on a falling edge, away from the sampling edge.
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// ==== tb_leaf_top.sv ====
module tb_leaf_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam leaf_pkg::leaf_id_t LEAF_ID    = 5'd3;
    localparam int                 FIFO_DEPTH = 4;
    localparam int                 NUM_OUT    = leaf_pkg::NUM_OUT_PORTS;

    logic              clk;
    logic              rst_n;
    leaf_pkg::packet_t din;
    leaf_pkg::packet_t dout;
    logic              resend;
    logic              ap_start;
    logic              start_seen;
    logic [15:0]       lfsr_state;

    leaf_pkg::route_t  route_cfg [NUM_OUT];
    leaf_pkg::packet_t exp_q [NUM_OUT][$];

    tb_clock_gen i_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    leaf_top #(
        .LEAF_ID    (LEAF_ID),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_leaf_top (
        .clk      (clk),
        .rst_n    (rst_n),
        .din      (din),
        .dout     (dout),
        .resend   (resend),
        .ap_start (ap_start)
    );

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("TB FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] exp_val,
                                   input logic [63:0] act_val);
        stop_on_error($sformatf("Mismatch at %0d ns: %s expected 0x%0h, got 0x%0h",
                                $time, name, exp_val, act_val));
    endtask

    // 16-bit Fibonacci LFSR with taps 16, 14, 13 and 11.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic random_word(output leaf_pkg::word_t w);
        w = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w = {w[30:0], lfsr_state[0]};
        end
    endtask

    function automatic leaf_pkg::packet_t make_packet(input leaf_pkg::leaf_id_t leaf,
                                                      input leaf_pkg::port_id_t port,
                                                      input leaf_pkg::addr_t addr,
                                                      input leaf_pkg::word_t payload);
        leaf_pkg::packet_t p;
        p.valid   = 1'b1;
        p.leaf    = leaf;
        p.port    = port;
        p.addr    = addr;
        p.payload = payload;
        return p;
    endfunction

    function automatic int pending_count();
        int n;
        n = 0;
        for (int j = 0; j < NUM_OUT; j++) begin
            n += exp_q[j].size();
        end
        return n;
    endfunction

    // Called on a falling edge, holds the packet for one cycle.
    task automatic send_packet(input leaf_pkg::packet_t p);
        din = p;
        @(negedge clk);
        din = '0;
    endtask

    // Result j is a + j*b, expected on output port j-1 with its route.
    task automatic send_pair(input leaf_pkg::word_t a, input leaf_pkg::word_t b);
        leaf_pkg::word_t res;
        send_packet(make_packet(LEAF_ID, 4'd1, 7'd0, a));
        send_packet(make_packet(LEAF_ID, 4'd2, 7'd0, b));
        for (int j = 1; j <= NUM_OUT; j++) begin
            res = a + leaf_pkg::word_t'(j) * b;
            exp_q[j-1].push_back(make_packet(route_cfg[j-1].leaf, route_cfg[j-1].port,
                                             leaf_pkg::addr_t'(j - 1), res));
        end
    endtask

    task automatic send_random_pair();
        leaf_pkg::word_t a;
        leaf_pkg::word_t b;
        random_word(a);
        random_word(b);
        send_pair(a, b);
    endtask

    // Other leaves, port 7 and a clear valid bit are traffic the leaf must drop.
    task automatic send_ignored();
        leaf_pkg::word_t w;
        leaf_pkg::packet_t p;
        random_word(w);
        send_packet(make_packet(LEAF_ID + 5'd1, 4'd1, 7'd0, w));
        send_packet(make_packet(LEAF_ID + 5'd9, 4'd2, 7'd0, w));
        send_packet(make_packet(LEAF_ID, 4'd7, 7'd0, w));
        p = make_packet(LEAF_ID, 4'd1, 7'd0, w);
        p.valid = 1'b0;
        send_packet(p);
    endtask

    task automatic wait_drained(input int max_cycles);
        int cycles;
        cycles = 0;
        while (pending_count() != 0) begin
            if (cycles >= max_cycles) begin
                stop_on_error($sformatf("timeout after %0d cycles with %0d results missing",
                                        max_cycles, pending_count()));
            end else begin
                @(negedge clk);
                cycles++;
            end
        end
    endtask

    // Every valid output packet must match the head of its port's queue.
    always @(posedge clk) begin
        int idx;
        leaf_pkg::packet_t exp_pkt;
        if (rst_n && dout.valid) begin
            idx = int'(dout.addr);
            assert (idx < NUM_OUT) else
                stop_on_error($sformatf("output packet addressed to unknown port %0d", idx));
            assert (exp_q[idx].size() > 0) else
                stop_on_error($sformatf("unexpected output packet on port %0d", idx));
            exp_pkt = exp_q[idx].pop_front();
            assert (dout.leaf == exp_pkt.leaf) else
                report_mismatch("dout.leaf", exp_pkt.leaf, dout.leaf);
            assert (dout.port == exp_pkt.port) else
                report_mismatch("dout.port", exp_pkt.port, dout.port);
            assert (dout.payload == exp_pkt.payload) else
                report_mismatch("dout.payload", exp_pkt.payload, dout.payload);
        end
    end

    a_resend_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        resend |-> (dout == '0))
        else report_mismatch("dout", 64'd0, $sampled(dout));

    a_no_output_before_start: assert property (@(posedge clk) disable iff (!rst_n)
        !start_seen |-> !dout.valid)
        else stop_on_error("output packet seen before ap_start");

    initial begin
        int cycles;
        din        = '0;
        resend     = 1'b0;
        ap_start   = 1'b0;
        start_seen = 1'b0;
        lfsr_state = 16'd43110;
        for (int j = 0; j < NUM_OUT; j++) begin
            route_cfg[j].leaf = leaf_pkg::leaf_id_t'(12 + j);
            route_cfg[j].port = leaf_pkg::port_id_t'(9 - j);
        end

        cycles = 0;
        while (rst_n !== 1'b1) begin
            if (cycles >= 20) begin
                stop_on_error("reset was never released");
            end else begin
                @(posedge clk);
                cycles++;
            end
        end
        @(negedge clk);
        assert (dout == '0) else report_mismatch("dout", 64'd0, dout);

        for (int j = 0; j < NUM_OUT; j++) begin
            send_packet(make_packet(LEAF_ID, 4'd0, leaf_pkg::addr_t'(j),
                                    {23'd0, route_cfg[j]}));
        end

        // Operands queued before start must wait in the FIFOs.
        for (int k = 0; k < FIFO_DEPTH; k++) begin
            send_random_pair();
        end
        repeat (10) @(negedge clk);

        ap_start   = 1'b1;
        start_seen = 1'b1;
        @(negedge clk);
        ap_start = 1'b0;
        wait_drained(200);

        for (int k = 0; k < 6; k++) begin
            send_random_pair();
            send_ignored();
            wait_drained(100);
        end

        resend = 1'b1;
        for (int k = 0; k < 3; k++) begin
            send_random_pair();
        end
        repeat (15) @(negedge clk);
        assert (pending_count() == 3 * NUM_OUT) else
            stop_on_error("results left the leaf while resend was high");
        resend = 1'b0;
        wait_drained(200);

        send_ignored();
        repeat (20) @(negedge clk);

        if (pending_count() == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            stop_on_error("expected results still outstanding at the end of the run");
        end
    end

endmodule

// ==== sources.f ====
leaf_pkg.sv
leaf_packet_rx.sv
leaf_port_fifo.sv
leaf_user_kernel.sv
leaf_packet_tx.sv
leaf_top.sv
tb_clock_gen.sv
tb_leaf_top.sv

// ==== Bender.yml ====
package:
  name: leaf

sources:
  - leaf_pkg.sv
  - leaf_packet_rx.sv
  - leaf_port_fifo.sv
  - leaf_user_kernel.sv
  - leaf_packet_tx.sv
  - leaf_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_leaf_top.sv
